// File: source/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

`define CPU_RESET_PC     32'h1c000000
`define CPU_NUM_REGS     32

// instruction word field positions (lsb of each field).
`define CPU_RD_LSB       0
`define CPU_RJ_LSB       5
`define CPU_RK_LSB       10
`define CPU_IMM12_LSB    10
`define CPU_IMM20_LSB    5
`define CPU_OFFS16_LSB   10

`endif

// File: source/cpu_pkg.sv
`default_nettype none
`include "cpu_settings.svh"

package cpu_pkg;

    typedef logic [$clog2(`CPU_NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_ADDI,
        OP_LU12I,
        OP_LD,
        OP_ST,
        OP_BEQ,
        OP_NOP
    } op_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fs2ds_t;

    typedef struct packed {
        logic [31:0] pc;
        op_t         op;
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic [31:0] st_data;     // rd value, only for st.w.
        reg_idx_t    dest;
        logic        we;
    } ds2es_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;      // alu result or memory address.
        reg_idx_t    dest;
        logic        we;
        logic        is_load;
    } es2ms_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] value;
        reg_idx_t    dest;
        logic        we;
    } ms2ws_t;

    // what a later stage reports back to decode.
    typedef struct packed {
        logic        valid;
        logic        we;
        reg_idx_t    dest;
        logic [31:0] value;
        logic        pending;     // load still in exe, value not there yet.
    } rf_fwd_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_t;

endpackage

`default_nettype wire

// File: source/if_stage.sv
`default_nettype none
`include "cpu_settings.svh"

module if_stage (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ds_allowin,
    input  cpu_pkg::br_t    br,
    input  logic [31:0]     inst_sram_rdata,
    output logic            inst_sram_en,
    output logic [3:0]      inst_sram_we,
    output logic [31:0]     inst_sram_addr,
    output logic [31:0]     inst_sram_wdata,
    output logic            fs2ds_valid,
    output cpu_pkg::fs2ds_t fs2ds
);
    logic        fs_valid;
    logic [31:0] fs_pc;
    logic        fs_allowin;
    logic [31:0] seq_pc;
    logic [31:0] next_pc;

    assign fs_allowin = !fs_valid || ds_allowin;
    assign seq_pc     = fs_pc + 32'd4;
    assign next_pc    = !fs_allowin ? fs_pc :      // stalled, re-read the held word.
                        br.taken    ? br.target : seq_pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fs_valid <= 1'b0;
            fs_pc    <= `CPU_RESET_PC - 32'd4;     // first request lands on the reset pc.
        end else if (fs_allowin) begin
            fs_valid <= 1'b1;
            fs_pc    <= next_pc;
        end
    end

    assign inst_sram_en    = 1'b1;
    assign inst_sram_we    = 4'h0;
    assign inst_sram_addr  = next_pc;
    assign inst_sram_wdata = 32'h0;

    assign fs2ds_valid = fs_valid && !br.taken;    // wrong-path fetch is dropped.
    assign fs2ds       = '{pc: fs_pc, inst: inst_sram_rdata};

endmodule

`default_nettype wire

// File: source/id_stage.sv
`default_nettype none
`include "cpu_settings.svh"

module id_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             fs2ds_valid,
    input  cpu_pkg::fs2ds_t  fs2ds,
    input  logic             es_allowin,
    input  cpu_pkg::rf_fwd_t es_fwd,
    input  cpu_pkg::rf_fwd_t ms_fwd,
    input  cpu_pkg::rf_fwd_t ws_fwd,
    output logic             ds_allowin,
    output cpu_pkg::br_t     br,
    output logic             ds2es_valid,
    output cpu_pkg::ds2es_t  ds2es
);
    import cpu_pkg::*;

    logic        ds_valid;
    fs2ds_t      ds_item;
    logic        ds_ready_go;
    logic [31:0] inst;
    op_t         op;
    reg_idx_t    rd;
    reg_idx_t    rj;
    reg_idx_t    rk;
    reg_idx_t    r2;
    logic        use_rj;
    logic        use_r2;
    logic        load_use;
    logic [31:0] val_j;
    logic [31:0] val_2;
    logic [31:0] src_b;
    logic [31:0] imm12;
    logic [31:0] imm20;
    logic [15:0] offs16;
    logic        rf_we;
    logic [31:0] rf [`CPU_NUM_REGS];

    function automatic logic fwd_hit(input rf_fwd_t f, input reg_idx_t r);
        return f.valid && f.we && (f.dest == r) && (r != '0);
    endfunction

    function automatic logic [31:0] rf_read(input reg_idx_t r);
        return (r == '0) ? 32'h0 : rf[r];
    endfunction

    assign ds_allowin  = !ds_valid || (ds_ready_go && es_allowin);
    assign ds2es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs2ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs2ds_valid && ds_allowin) begin
            ds_item <= fs2ds;
        end
        if (ws_fwd.valid && ws_fwd.we && ws_fwd.dest != '0) begin
            rf[ws_fwd.dest] <= ws_fwd.value;
        end
    end

    assign inst   = ds_item.inst;
    assign rd     = inst[`CPU_RD_LSB +: 5];
    assign rj     = inst[`CPU_RJ_LSB +: 5];
    assign rk     = inst[`CPU_RK_LSB +: 5];
    assign imm12  = {{20{inst[`CPU_IMM12_LSB + 11]}}, inst[`CPU_IMM12_LSB +: 12]};
    assign imm20  = {inst[`CPU_IMM20_LSB +: 20], 12'h0};
    assign offs16 = inst[`CPU_OFFS16_LSB +: 16];

    always_comb begin
        op = OP_NOP;
        if (inst[31:15] == 17'h00020) op = OP_ADD;
        else if (inst[31:15] == 17'h00022) op = OP_SUB;
        else if (inst[31:22] == 10'h00a) op = OP_ADDI;
        else if (inst[31:25] == 7'h0a) op = OP_LU12I;
        else if (inst[31:22] == 10'h0a2) op = OP_LD;
        else if (inst[31:22] == 10'h0a6) op = OP_ST;
        else if (inst[31:26] == 6'h16) op = OP_BEQ;
    end

    assign r2     = (op == OP_ADD || op == OP_SUB) ? rk : rd;     // st.w and beq read rd.
    assign use_rj = (op != OP_LU12I) && (op != OP_NOP);
    assign use_r2 = (op == OP_ADD) || (op == OP_SUB) || (op == OP_ST) || (op == OP_BEQ);
    assign rf_we  = (op == OP_ADD) || (op == OP_SUB) || (op == OP_ADDI) ||
                    (op == OP_LU12I) || (op == OP_LD);

    // nearest producer wins.
    assign val_j = fwd_hit(es_fwd, rj) ? es_fwd.value :
                   fwd_hit(ms_fwd, rj) ? ms_fwd.value :
                   fwd_hit(ws_fwd, rj) ? ws_fwd.value : rf_read(rj);
    assign val_2 = fwd_hit(es_fwd, r2) ? es_fwd.value :
                   fwd_hit(ms_fwd, r2) ? ms_fwd.value :
                   fwd_hit(ws_fwd, r2) ? ws_fwd.value : rf_read(r2);

    assign load_use    = es_fwd.pending && ((use_rj && fwd_hit(es_fwd, rj)) ||
                                            (use_r2 && fwd_hit(es_fwd, r2)));
    assign ds_ready_go = !load_use;

    assign src_b = (op == OP_ADD || op == OP_SUB) ? val_2 :
                   (op == OP_LU12I)               ? imm20 : imm12;

    assign ds2es = '{pc: ds_item.pc, op: op, src_a: val_j, src_b: src_b,
                     st_data: val_2, dest: rd, we: rf_we};

    assign br.taken  = ds_valid && ds_ready_go && es_allowin && (op == OP_BEQ) &&
                       (val_j == val_2);
    assign br.target = ds_item.pc + {{14{offs16[15]}}, offs16, 2'b00};

endmodule

`default_nettype wire

// File: source/exe_stage.sv
`default_nettype none

module exe_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ds2es_valid,
    input  cpu_pkg::ds2es_t  ds2es,
    input  logic             ms_allowin,
    output logic             es_allowin,
    output logic             es2ms_valid,
    output cpu_pkg::es2ms_t  es2ms,
    output cpu_pkg::rf_fwd_t es_fwd,
    output logic             data_sram_en,
    output logic [3:0]       data_sram_we,
    output logic [31:0]      data_sram_addr,
    output logic [31:0]      data_sram_wdata
);
    import cpu_pkg::*;

    logic        es_valid;
    ds2es_t      es_item;
    logic [31:0] alu_result;
    logic        is_load;
    logic        mem_go;

    assign es_allowin = !es_valid || ms_allowin;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds2es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds2es_valid && es_allowin) begin
            es_item <= ds2es;
        end
    end

    always_comb begin
        case (es_item.op)
            OP_SUB:   alu_result = es_item.src_a - es_item.src_b;
            OP_LU12I: alu_result = es_item.src_b;
            default:  alu_result = es_item.src_a + es_item.src_b;  // also ld/st address.
        endcase
    end

    assign is_load = (es_item.op == OP_LD);
    assign mem_go  = es_valid && ms_allowin;   // request only as the item leaves.

    assign data_sram_en    = mem_go && (is_load || es_item.op == OP_ST);
    assign data_sram_we    = (mem_go && es_item.op == OP_ST) ? 4'hf : 4'h0;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = es_item.st_data;

    assign es2ms_valid = es_valid;
    assign es2ms       = '{pc: es_item.pc, result: alu_result, dest: es_item.dest,
                           we: es_item.we, is_load: is_load};

    assign es_fwd = '{valid: es_valid, we: es_item.we, dest: es_item.dest,
                      value: alu_result, pending: is_load};

endmodule

`default_nettype wire

// File: source/mem_stage.sv
`default_nettype none

module mem_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             es2ms_valid,
    input  cpu_pkg::es2ms_t  es2ms,
    input  logic             ws_allowin,
    input  logic [31:0]      data_sram_rdata,
    output logic             ms_allowin,
    output logic             ms2ws_valid,
    output cpu_pkg::ms2ws_t  ms2ws,
    output cpu_pkg::rf_fwd_t ms_fwd
);
    import cpu_pkg::*;

    logic        ms_valid;
    es2ms_t      ms_item;
    logic [31:0] final_value;

    assign ms_allowin = !ms_valid || ws_allowin;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es2ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es2ms_valid && ms_allowin) begin
            ms_item <= es2ms;
        end
    end

    assign final_value = ms_item.is_load ? data_sram_rdata : ms_item.result;

    assign ms2ws_valid = ms_valid;
    assign ms2ws       = '{pc: ms_item.pc, value: final_value, dest: ms_item.dest,
                           we: ms_item.we};
    assign ms_fwd      = '{valid: ms_valid, we: ms_item.we, dest: ms_item.dest,
                           value: final_value, pending: 1'b0};

endmodule

`default_nettype wire

// File: source/wb_stage.sv
`default_nettype none

module wb_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             ms2ws_valid,
    input  cpu_pkg::ms2ws_t  ms2ws,
    output logic             ws_allowin,
    output cpu_pkg::rf_fwd_t ws_fwd,
    output logic [31:0]      debug_wb_pc,
    output logic [3:0]       debug_wb_rf_we,
    output logic [4:0]       debug_wb_rf_wnum,
    output logic [31:0]      debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic   ws_valid;
    ms2ws_t ws_item;
    logic   rf_write;

    assign ws_allowin = 1'b1;   // retires one item every cycle.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= ms2ws_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms2ws_valid) begin
            ws_item <= ms2ws;
        end
    end

    assign rf_write = ws_valid && ws_item.we && (ws_item.dest != '0);

    assign ws_fwd = '{valid: ws_valid, we: ws_item.we, dest: ws_item.dest,
                      value: ws_item.value, pending: 1'b0};

    assign debug_wb_pc       = ws_item.pc;
    assign debug_wb_rf_we    = rf_write ? 4'hf : 4'h0;
    assign debug_wb_rf_wnum  = ws_item.dest;
    assign debug_wb_rf_wdata = ws_item.value;

endmodule

`default_nettype wire

// File: source/mycpu_top.sv
`default_nettype none

module mycpu_top (
    input  logic        clk,
    input  logic        rst_n,
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    output logic        data_sram_en,
    output logic [3:0]  data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic    ds_allowin;
    logic    es_allowin;
    logic    ms_allowin;
    logic    ws_allowin;
    logic    fs2ds_valid;
    logic    ds2es_valid;
    logic    es2ms_valid;
    logic    ms2ws_valid;
    fs2ds_t  fs2ds;
    ds2es_t  ds2es;
    es2ms_t  es2ms;
    ms2ws_t  ms2ws;
    br_t     br;
    rf_fwd_t es_fwd;
    rf_fwd_t ms_fwd;
    rf_fwd_t ws_fwd;

    if_stage if_stage_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .ds_allowin      (ds_allowin),
        .br              (br),
        .inst_sram_rdata (inst_sram_rdata),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_we    (inst_sram_we),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_wdata (inst_sram_wdata),
        .fs2ds_valid     (fs2ds_valid),
        .fs2ds           (fs2ds)
    );

    id_stage id_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fs2ds_valid (fs2ds_valid),
        .fs2ds       (fs2ds),
        .es_allowin  (es_allowin),
        .es_fwd      (es_fwd),
        .ms_fwd      (ms_fwd),
        .ws_fwd      (ws_fwd),
        .ds_allowin  (ds_allowin),
        .br          (br),
        .ds2es_valid (ds2es_valid),
        .ds2es       (ds2es)
    );

    exe_stage exe_stage_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .ds2es_valid     (ds2es_valid),
        .ds2es           (ds2es),
        .ms_allowin      (ms_allowin),
        .es_allowin      (es_allowin),
        .es2ms_valid     (es2ms_valid),
        .es2ms           (es2ms),
        .es_fwd          (es_fwd),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    mem_stage mem_stage_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .es2ms_valid     (es2ms_valid),
        .es2ms           (es2ms),
        .ws_allowin      (ws_allowin),
        .data_sram_rdata (data_sram_rdata),
        .ms_allowin      (ms_allowin),
        .ms2ws_valid     (ms2ws_valid),
        .ms2ws           (ms2ws),
        .ms_fwd          (ms_fwd)
    );

    wb_stage wb_stage_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .ms2ws_valid       (ms2ws_valid),
        .ms2ws             (ms2ws),
        .ws_allowin        (ws_allowin),
        .ws_fwd            (ws_fwd),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

// File: sim/mycpu_sva.sv
`default_nettype none

module mycpu_sva (
    input logic       clk,
    input logic       rst_n,
    input logic       data_sram_en,
    input logic [3:0] data_sram_we,
    input logic [3:0] debug_wb_rf_we,
    input logic [4:0] debug_wb_rf_wnum,
    input logic       fs2ds_valid,
    input logic       ds2es_valid,
    input logic       es2ms_valid,
    input logic       ms2ws_valid
);

    int fails = 0;     // number of failed assertions.

    a_we_with_en: assert property (@(posedge clk) disable iff (!rst_n)
        (data_sram_we != 4'h0) |-> data_sram_en)
        else begin
            fails++;
            $error("data_sram_we is set while data_sram_en is low");
        end

    a_wnum_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        (debug_wb_rf_we != 4'h0) |-> (debug_wb_rf_wnum != 5'd0))
        else begin
            fails++;
            $error("register write-back reported for r0");
        end

    // every stage is empty one cycle after a reset edge.
    a_quiet_after_reset: assert property (@(posedge clk)
        !rst_n |=> (!fs2ds_valid && !ds2es_valid && !es2ms_valid && !ms2ws_valid &&
                    debug_wb_rf_we == 4'h0))
        else begin
            fails++;
            $error("a stage is valid in the cycle after reset");
        end

endmodule

bind mycpu_top mycpu_sva mycpu_sva_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .data_sram_en     (data_sram_en),
    .data_sram_we     (data_sram_we),
    .debug_wb_rf_we   (debug_wb_rf_we),
    .debug_wb_rf_wnum (debug_wb_rf_wnum),
    .fs2ds_valid      (fs2ds_valid),
    .ds2es_valid      (ds2es_valid),
    .es2ms_valid      (es2ms_valid),
    .ms2ws_valid      (ms2ws_valid)
);

`default_nettype wire

// File: sim/tb_top.sv
`default_nettype none
`include "cpu_settings.svh"

module tb_top;
    import cpu_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] rom [64];
    logic [31:0] ram [64];
    logic [31:0] model_ram [64];
    logic        inst_req_en;
    logic [31:0] inst_req_addr;
    logic        data_req_en;
    logic [3:0]  data_req_we;
    logic [31:0] data_req_addr;
    logic [31:0] data_req_wdata;
    int          byte_i;

    op_t         prog_op [64];
    reg_idx_t    prog_rd [64];
    reg_idx_t    prog_rj [64];
    reg_idx_t    prog_rk [64];
    int          prog_imm [64];
    int          prog_len;

    logic [31:0] exp_pc [$];
    reg_idx_t    exp_wnum [$];
    logic [31:0] exp_wdata [$];

    logic [31:0] rng_state;
    int          errors;
    int          checks;

    mycpu_top mycpu_top_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_we      (inst_sram_we),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // requests are taken mid-cycle, where the DUT outputs have settled.
    always @(negedge clk) begin
        if (inst_sram_we != 4'h0) begin
            errors++;
            $display("write request on the instruction SRAM port at %h", inst_sram_addr);
        end
        inst_req_en    <= inst_sram_en;
        inst_req_addr  <= inst_sram_addr;
        data_req_en    <= data_sram_en;
        data_req_we    <= data_sram_we;
        data_req_addr  <= data_sram_addr;
        data_req_wdata <= data_sram_wdata;
    end

    always @(posedge clk) begin
        #2;
        if (inst_req_en) begin
            inst_sram_rdata = rom[inst_req_addr[7:2]];
        end
        if (data_req_en) begin
            data_sram_rdata = ram[data_req_addr[7:2]];
            for (byte_i = 0; byte_i < 4; byte_i++) begin
                if (data_req_we[byte_i]) begin
                    ram[data_req_addr[7:2]][byte_i*8 +: 8] = data_req_wdata[byte_i*8 +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        logic [31:0] addr;
        addr = 32'(idx) << 2;
        return {addr[15:0], ~addr[15:0]} ^ 32'h3c5a_0000;
    endfunction

    // LA32R encodings of the supported subset.
    function automatic logic [31:0] encode(input op_t op, input reg_idx_t rd, input reg_idx_t rj,
                                           input reg_idx_t rk, input int imm);
        logic [31:0] iv;
        iv = imm;
        case (op)
            OP_ADD:   return {17'h00020, rk, rj, rd};
            OP_SUB:   return {17'h00022, rk, rj, rd};
            OP_ADDI:  return {10'h00a, iv[11:0], rj, rd};
            OP_LU12I: return {7'h0a, iv[19:0], rd};
            OP_LD:    return {10'h0a2, iv[11:0], rj, rd};
            OP_ST:    return {10'h0a6, iv[11:0], rj, rd};
            OP_BEQ:   return {6'h16, iv[15:0], rj, rd};
            default:  return 32'h0;
        endcase
    endfunction

    function automatic int pick_src(input logic [31:0] written, input logic [4:0] r);
        return written[r] ? int'(r) : 0;
    endfunction

    task automatic add_inst(input op_t op, input int rd, input int rj, input int rk,
                            input int imm);
        prog_op[prog_len]  = op;
        prog_rd[prog_len]  = reg_idx_t'(rd);
        prog_rj[prog_len]  = reg_idx_t'(rj);
        prog_rk[prog_len]  = reg_idx_t'(rk);
        prog_imm[prog_len] = imm;
        prog_len++;
    endtask

    task automatic check_word(input string test, input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: %s expected %h actual %h", test, what, expected, actual);
        end
    endtask

    task automatic check_reg(input string test, input string what, input reg_idx_t expected,
                             input reg_idx_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: %s expected r%0d actual r%0d", test, what, expected, actual);
        end
    endtask

    // in-order reference run of the program description.
    task automatic build_expected();
        logic [31:0] mrf [32];
        logic [31:0] addr;
        logic [31:0] value;
        int          idx;
        int          next_idx;
        int          steps;
        bit          writes;
        exp_pc.delete();
        exp_wnum.delete();
        exp_wdata.delete();
        for (idx = 0; idx < 32; idx++) begin
            mrf[idx] = 32'h0;
        end
        for (idx = 0; idx < 64; idx++) begin
            model_ram[idx] = fill_word(idx);
        end
        idx   = 0;
        steps = 0;
        while (idx >= 0 && idx < prog_len && steps < 500) begin
            next_idx = idx + 1;
            writes   = 1'b1;
            value    = 32'h0;
            addr     = mrf[prog_rj[idx]] + 32'(prog_imm[idx]);
            case (prog_op[idx])
                OP_ADD:   value = mrf[prog_rj[idx]] + mrf[prog_rk[idx]];
                OP_SUB:   value = mrf[prog_rj[idx]] - mrf[prog_rk[idx]];
                OP_ADDI:  value = addr;
                OP_LU12I: value = 32'(prog_imm[idx]) << 12;
                OP_LD:    value = model_ram[addr[7:2]];
                OP_ST: begin
                    model_ram[addr[7:2]] = mrf[prog_rd[idx]];
                    writes = 1'b0;
                end
                OP_BEQ: begin
                    if (mrf[prog_rj[idx]] == mrf[prog_rd[idx]]) begin
                        next_idx = idx + prog_imm[idx];
                    end
                    writes = 1'b0;
                end
                default: writes = 1'b0;
            endcase
            if (writes && prog_rd[idx] != 0) begin
                mrf[prog_rd[idx]] = value;
                exp_pc.push_back(`CPU_RESET_PC + 32'(idx) * 32'd4);
                exp_wnum.push_back(prog_rd[idx]);
                exp_wdata.push_back(value);
            end
            idx = next_idx;
            steps++;
        end
    endtask

    task automatic reset_dut(input string name, input bit check_quiet);
        int i;
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        #1;
        for (i = 0; i < 64; i++) begin
            rom[i] = (i < prog_len) ?
                     encode(prog_op[i], prog_rd[i], prog_rj[i], prog_rk[i], prog_imm[i]) : 32'h0;
            ram[i] = fill_word(i);
        end
        build_expected();
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            if (check_quiet && i > 0) begin
                check_word(name, "inst_sram_en in reset", 32'h1, {31'h0, inst_sram_en});
                check_word(name, "inst_sram_addr in reset", `CPU_RESET_PC, inst_sram_addr);
                check_word(name, "debug_wb_rf_we in reset", 32'h0, {28'h0, debug_wb_rf_we});
                check_word(name, "data_sram_en in reset", 32'h0, {31'h0, data_sram_en});
            end
            @(posedge clk);
            #2;
        end
        rst_n = 1'b1;
        if (check_quiet) begin
            for (i = 0; i < 3; i++) begin
                @(negedge clk);
                check_word(name, "debug_wb_rf_we after reset", 32'h0, {28'h0, debug_wb_rf_we});
                check_word(name, "data_sram_en after reset", 32'h0, {31'h0, data_sram_en});
            end
        end
    endtask

    task automatic collect_trace(input string name);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < exp_pc.size() && cycles < 300) begin
            @(negedge clk);
            cycles++;
            if (debug_wb_rf_we != 4'h0) begin
                check_word(name, "trace we", 32'hf, {28'h0, debug_wb_rf_we});
                check_word(name, "trace pc", exp_pc[seen], debug_wb_pc);
                check_reg(name, "trace wnum", exp_wnum[seen], reg_idx_t'(debug_wb_rf_wnum));
                check_word(name, "trace wdata", exp_wdata[seen], debug_wb_rf_wdata);
                seen++;
            end
        end
        if (seen < exp_pc.size()) begin
            errors++;
            $display("%s: timed out after %0d cycles, saw %0d of %0d write-backs",
                     name, cycles, seen, exp_pc.size());
        end
        // the nop tail retires nothing.
        for (cycles = 0; cycles < 12; cycles++) begin
            @(negedge clk);
            if (debug_wb_rf_we != 4'h0) begin
                errors++;
                $display("%s: unexpected write-back of r%0d at pc %h",
                         name, debug_wb_rf_wnum, debug_wb_pc);
            end
        end
    endtask

    task automatic run_program(input string name, input bit check_quiet);
        int i;
        reset_dut(name, check_quiet);
        collect_trace(name);
        for (i = 0; i < 64; i++) begin
            check_word(name, $sformatf("ram[%0d]", i), model_ram[i], ram[i]);
        end
    endtask

    task automatic test_reset_quiet();
        prog_len = 0;
        add_inst(OP_LU12I, 1, 0, 0, 'h12345);
        add_inst(OP_ADDI, 2, 1, 0, 'h7f);
        add_inst(OP_ST, 2, 0, 0, 'h10);
        run_program("reset_quiet", 1'b1);
    endtask

    task automatic test_arithmetic();
        logic [31:0] r;
        logic [31:0] written;
        int          n;
        int          rd;
        prog_len = 0;
        written  = 32'h1;
        for (n = 0; n < 14; n++) begin
            rng_state = xorshift(rng_state);
            r  = rng_state;
            rd = 1 + int'(r[31:27]) % 31;
            case (r[1:0])
                2'd0: add_inst(OP_LU12I, rd, 0, 0, int'(r[26:7]));
                2'd1: add_inst(OP_ADDI, rd, pick_src(written, r[6:2]), 0,
                               int'($signed(r[18:7])));
                2'd2: add_inst(OP_ADD, rd, pick_src(written, r[6:2]),
                               pick_src(written, r[11:7]), 0);
                default: add_inst(OP_SUB, rd, pick_src(written, r[6:2]),
                                  pick_src(written, r[16:12]), 0);
            endcase
            written[rd] = 1'b1;
        end
        run_program("arithmetic", 1'b0);
    endtask

    task automatic test_dependencies();
        prog_len = 0;
        add_inst(OP_ADDI, 1, 0, 0, 5);
        add_inst(OP_ADDI, 2, 1, 0, 3);       // from exe.
        add_inst(OP_ADD, 3, 2, 1, 0);        // exe and mem.
        add_inst(OP_SUB, 4, 3, 1, 0);        // r1 from wb.
        add_inst(OP_ADD, 5, 4, 4, 0);
        add_inst(OP_ADDI, 5, 5, 0, -7);
        add_inst(OP_ADD, 6, 5, 2, 0);
        add_inst(OP_LU12I, 7, 0, 0, 'hfffff);
        add_inst(OP_ADD, 7, 7, 6, 0);
        add_inst(OP_SUB, 8, 0, 7, 0);
        run_program("dependencies", 1'b0);
    endtask

    task automatic test_memory();
        prog_len = 0;
        add_inst(OP_LU12I, 1, 0, 0, 'hcafe0);
        add_inst(OP_ADDI, 1, 1, 0, 'h123);
        add_inst(OP_ST, 1, 0, 0, 'h40);
        add_inst(OP_LD, 2, 0, 0, 'h40);      // reads the word just stored.
        add_inst(OP_ADD, 3, 2, 2, 0);        // load-use.
        add_inst(OP_LD, 4, 0, 0, 'h80);
        add_inst(OP_ADDI, 5, 4, 0, 1);
        add_inst(OP_ADDI, 6, 0, 0, 'h44);
        add_inst(OP_ST, 5, 6, 0, 8);
        add_inst(OP_LD, 7, 6, 0, 8);
        add_inst(OP_ST, 7, 0, 0, 'h50);
        run_program("memory", 1'b0);
    endtask

    task automatic test_branches();
        prog_len = 0;
        add_inst(OP_ADDI, 1, 0, 0, 3);
        add_inst(OP_ADDI, 2, 0, 0, 3);
        add_inst(OP_BEQ, 2, 1, 0, 3);        // taken, skips two.
        add_inst(OP_ADDI, 3, 0, 0, 'h11);
        add_inst(OP_ADDI, 4, 0, 0, 'h22);
        add_inst(OP_ADDI, 5, 0, 0, 'h33);
        add_inst(OP_BEQ, 5, 1, 0, 2);        // not taken.
        add_inst(OP_ADDI, 6, 0, 0, 'h44);
        add_inst(OP_ADDI, 7, 0, 0, 3);
        add_inst(OP_ADDI, 7, 7, 0, -1);      // loop body.
        add_inst(OP_BEQ, 0, 7, 0, 2);
        add_inst(OP_BEQ, 0, 0, 0, -2);
        add_inst(OP_ADDI, 8, 7, 0, 'h55);
        add_inst(OP_BEQ, 0, 0, 0, 2);
        add_inst(OP_ADDI, 9, 0, 0, 'h66);
        add_inst(OP_ADDI, 10, 0, 0, 'h77);
        run_program("branches", 1'b0);
    endtask

    initial begin
        rst_n           = 1'b0;
        inst_sram_rdata = 32'h0;
        data_sram_rdata = 32'h0;
        inst_req_en     = 1'b0;
        inst_req_addr   = 32'h0;
        data_req_en     = 1'b0;
        data_req_we     = 4'h0;
        data_req_addr   = 32'h0;
        data_req_wdata  = 32'h0;
        rng_state       = 32'hb146;
        prog_len        = 0;
        errors          = 0;
        checks          = 0;
        test_reset_quiet();
        test_arithmetic();
        test_dependencies();
        test_memory();
        test_branches();
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 mycpu_top_i.mycpu_sva_i.fails);
        if (errors == 0 && mycpu_top_i.mycpu_sva_i.fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/cpu_pkg.sv
source/if_stage.sv
source/id_stage.sv
source/exe_stage.sv
source/mem_stage.sv
source/wb_stage.sv
source/mycpu_top.sv
sim/mycpu_sva.sv
sim/tb_top.sv
